//--- rs_issue.f
+incdir+src
src/rs_pkg.sv
src/fu_issue_if.sv
src/rs_dispatch.sv
src/rs_station.sv
src/rs_bank.sv
src/rs_select.sv
src/alu_unit.sv
src/rs_issue_top.sv
verification/rs_issue_assertions.sv
verification/rs_issue_tb.sv

//--- Bender.yml
package:
  name: rs_issue

sources:
  - include_dirs:
      - src
    files:
      - src/rs_pkg.sv
      - src/fu_issue_if.sv
      - src/rs_dispatch.sv
      - src/rs_station.sv
      - src/rs_bank.sv
      - src/rs_select.sv
      - src/alu_unit.sv
      - src/rs_issue_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verification/rs_issue_assertions.sv
      - verification/rs_issue_tb.sv

//--- verification/rs_issue_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for rs_issue_top, tags 1..7 per batch
// a tag is reused only after its result is seen
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_issue_tb
    import rs_pkg::*;
();

    logic                 clk;
    logic                 reset;
    logic                 flush;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [75:0]          wb_dat_w;
    logic                 wb_ack;
    logic [`RS_COUNT-1:0] rs_busy;
    logic                 cdb_valid;
    logic [`TAG_W-1:0]    cdb_tag;
    logic [`DATA_W-1:0]   cdb_result;

    // program indexed by tag
    alu_op_t              prog_op  [8];
    logic [`TAG_W-1:0]    prog_qj  [8];
    logic [`DATA_W-1:0]   prog_vj  [8];
    logic [`TAG_W-1:0]    prog_qk  [8];
    logic [`DATA_W-1:0]   prog_vk  [8];
    logic [`DATA_W-1:0]   exp_result [8];
    logic                 expect_on  [8];
    int                   pending;
    logic                 saw_full;
    logic [15:0]          lfsr_state;

    rs_issue_top dut (.*);

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %s: got 0x%h expected 0x%h", name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // taps 16 14 13 11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // program order entry, expected value resolved from earlier tags
    task automatic set_prog(input int tag, input alu_op_t op, input int qj,
                            input logic [31:0] vj, input int qk, input logic [31:0] vk,
                            input logic expected);
        logic [31:0] a;
        logic [31:0] b;
        a = (qj != 0) ? exp_result[qj] : vj;
        b = (qk != 0) ? exp_result[qk] : vk;
        prog_op[tag] = op;
        prog_qj[tag] = 3'(qj);
        prog_vj[tag] = vj;
        prog_qk[tag] = 3'(qk);
        prog_vk[tag] = vk;
        exp_result[tag] = alu_ref(op, a, b);
        expect_on[tag] = expected;
        if (expected) begin
            pending++;
        end
    endtask

    // called and returns on a falling edge
    task automatic dispatch(input int tag);
        int cycles;
        cycles = 0;
        wb_dat_w = {prog_op[tag], 3'(tag), prog_qj[tag], prog_vj[tag],
                    prog_qk[tag], prog_vk[tag]};
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        // an ack still high from the previous write does not count
        do begin
            @(negedge clk);
            cycles++;
            if (rs_busy == '1 && !wb_ack) begin
                saw_full = 1'b1;
            end
            if (cycles > 100) begin
                abort_run("timeout waiting for dispatch ack");
            end
        end while (!wb_ack);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (pending != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > 300) begin
                abort_run("timeout waiting for CDB results");
            end
        end
    endtask

    // compare process
    always @(negedge clk) begin
        if (!reset && cdb_valid) begin
            if (!expect_on[cdb_tag]) begin
                abort_run("unexpected or duplicate CDB result");
            end
            check("cdb_result", cdb_result, exp_result[cdb_tag]);
            expect_on[cdb_tag] = 1'b0;
            pending--;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_dat_w = '0;
        pending = 0;
        saw_full = 1'b0;
        lfsr_state = 16'd14;
        for (int t = 0; t < 8; t++) begin
            expect_on[t] = 1'b0;
            exp_result[t] = '0;
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check("wb_ack", wb_ack, 0);
        check("rs_busy", rs_busy, 0);
        check("cdb_valid", cdb_valid, 0);

        // each op once, independent operands
        for (int op = 0; op < 8; op++) begin
            set_prog((op % 4) + 1, alu_op_t'(op), 0, rand_bits(32), 0, rand_bits(32), 1'b1);
            dispatch((op % 4) + 1);
            if (op % 4 == 3) begin
                wait_drain();
            end
        end

        // dependent pair, gap sweep covers dispatch on the broadcast edge
        for (int gap = 0; gap < 4; gap++) begin
            set_prog(1, ALU_ADD, 0, rand_bits(32), 0, rand_bits(32), 1'b1);
            set_prog(2, alu_op_t'(rand_bits(3)), 0, rand_bits(32), 1, '0, 1'b1);
            set_prog(3, ALU_SUB, 2, '0, 0, rand_bits(32), 1'b1);
            dispatch(1);
            repeat (gap) @(negedge clk);
            dispatch(2);
            dispatch(3);
            wait_drain();
        end

        // slow chain longer than the bank
        set_prog(1, ALU_XOR, 0, rand_bits(32), 0, rand_bits(32), 1'b1);
        for (int t = 2; t < 8; t++) begin
            set_prog(t, alu_op_t'(rand_bits(3)), t - 1, '0, 0, rand_bits(32), 1'b1);
        end
        for (int t = 1; t < 8; t++) begin
            dispatch(t);
        end
        // tag 1 retired long ago, its reuse meets a full bank
        set_prog(1, alu_op_t'(rand_bits(3)), 7, '0, 0, rand_bits(32), 1'b1);
        dispatch(1);
        wait_drain();
        check("saw_full", saw_full, 1);

        // entries waiting on tags that never arrive, one op caught in the ALU
        set_prog(1, ALU_ADD, 6, '0, 0, rand_bits(32), 1'b0);
        set_prog(2, ALU_OR, 0, rand_bits(32), 7, '0, 1'b0);
        set_prog(3, ALU_AND, 0, rand_bits(32), 0, rand_bits(32), 1'b0);
        for (int t = 1; t < 4; t++) begin
            dispatch(t);
        end
        repeat (2) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        check("rs_busy", rs_busy, 0);
        repeat (20) @(negedge clk);

        // fresh batch after flush
        for (int t = 1; t < 6; t++) begin
            if (t > 2) begin
                set_prog(t, alu_op_t'(rand_bits(3)), t - 2, '0, t - 1, '0, 1'b1);
            end else begin
                set_prog(t, alu_op_t'(rand_bits(3)), 0, rand_bits(32), 0, rand_bits(32), 1'b1);
            end
            dispatch(t);
        end
        wait_drain();

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/rs_issue_assertions.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// protocol properties bound to rs_issue_top
// all checks are disabled during reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_issue_assertions (
    input wire logic                  clk,
    input wire logic                  reset,
    input wire logic                  flush,
    input wire logic                  wb_cyc,
    input wire logic                  wb_stb,
    input wire logic                  wb_we,
    input wire logic                  wb_ack,
    input wire logic [`RS_COUNT-1:0]  rs_busy,
    input wire logic                  cdb_valid,
    input wire logic [`TAG_W-1:0]     cdb_tag
);

    // ack lasts one cycle
    ack_single: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack) else $error("wb_ack held longer than one cycle");

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb && wb_we)) else $error("wb_ack without request");

    // a write needs a free station at the edge before ack
    no_ack_when_full: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(rs_busy) != '1) else $error("wb_ack while all stations busy");

    flush_clears: assert property (@(posedge clk) disable iff (reset)
        $past(flush) |-> (rs_busy == '0) && !cdb_valid) else $error("state left after flush");

    cdb_tag_nonzero: assert property (@(posedge clk) disable iff (reset)
        cdb_valid |-> cdb_tag != '0) else $error("cdb broadcast with tag 0");

endmodule

bind rs_issue_top rs_issue_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_ack    (wb_ack),
    .rs_busy   (rs_busy),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag)
);

`default_nettype wire

//--- src/rs_issue_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dispatch, stations, select and ALU
// caller owns ROB tags and keeps them unique
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_issue_top
    import rs_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [$bits(rs_dispatch_t)-1:0]   wb_dat_w,
    output logic                              wb_ack,
    output logic [`RS_COUNT-1:0]              rs_busy,
    output logic                              cdb_valid,
    output logic [`TAG_W-1:0]                 cdb_tag,
    output logic [`DATA_W-1:0]                cdb_result
);

    logic [`RS_COUNT-1:0] write_en;
    logic [`RS_COUNT-1:0] consume;
    rs_entry_t            entry;
    rs_out_t              station_out [`RS_COUNT];
    cdb_packet_t          cdb;

    fu_issue_if issue_bus ();

    rs_dispatch u_dispatch (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat_w (wb_dat_w),
        .busy     (rs_busy),
        .wb_ack   (wb_ack),
        .write_en (write_en),
        .entry    (entry)
    );

    rs_bank u_bank (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .write_en    (write_en),
        .entry       (entry),
        .cdb         (cdb),
        .consume     (consume),
        .busy        (rs_busy),
        .station_out (station_out)
    );

    rs_select u_select (
        .station_out (station_out),
        .busy        (rs_busy),
        .consume     (consume),
        .issue       (issue_bus.sel)
    );

    alu_unit u_alu (
        .clk   (clk),
        .reset (reset),
        .flush (flush),
        .issue (issue_bus.alu),
        .cdb   (cdb)
    );

    // CDB also leaves the block for the ROB side
    assign cdb_valid  = cdb.valid;
    assign cdb_tag    = cdb.tag;
    assign cdb_result = cdb.result;

endmodule

`default_nettype wire

//--- src/alu_unit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-stage integer ALU, result on the CDB
// accepts one op per cycle, flush kills both stages
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module alu_unit
    import rs_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    fu_issue_if.alu      issue,
    output cdb_packet_t  cdb
);

    logic                s1_valid;
    alu_op_t             s1_op;
    logic [`TAG_W-1:0]   s1_tag;
    logic [`DATA_W-1:0]  s1_a;
    logic [`DATA_W-1:0]  s1_b;
    logic [`DATA_W-1:0]  result;
    logic                s2_valid;
    logic [`TAG_W-1:0]   s2_tag;
    logic [`DATA_W-1:0]  s2_result;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_op     <= issue.op;
        s1_tag    <= issue.tag;
        s1_a      <= issue.a;
        s1_b      <= issue.b;
        s2_tag    <= s1_tag;
        s2_result <= result;
    end

    // execute in stage two
    always_comb begin
        case (s1_op)
            ALU_ADD: result = s1_a + s1_b;
            ALU_SUB: result = s1_a - s1_b;
            ALU_AND: result = s1_a & s1_b;
            ALU_OR:  result = s1_a | s1_b;
            ALU_XOR: result = s1_a ^ s1_b;
            ALU_SLL: result = s1_a << s1_b[4:0];
            ALU_SRL: result = s1_a >> s1_b[4:0];
            default: result = {{(`DATA_W - 1){1'b0}}, ($signed(s1_a) < $signed(s1_b))};
        endcase
    end

    assign cdb = '{valid: s2_valid, tag: s2_tag, result: s2_result};

endmodule

`default_nettype wire

//--- src/rs_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational pick of one ready station
// lowest index first, no age ordering
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_select
    import rs_pkg::*;
(
    input  rs_out_t               station_out [`RS_COUNT],
    input  logic [`RS_COUNT-1:0]  busy,
    output logic [`RS_COUNT-1:0]  consume,
    fu_issue_if.sel               issue
);

    always_comb begin
        consume     = '0;
        issue.valid = 1'b0;
        issue.op    = ALU_ADD;
        issue.tag   = '0;
        issue.a     = '0;
        issue.b     = '0;

        // walk down so the lowest ready index is the last one written
        for (int i = `RS_COUNT - 1; i >= 0; i--) begin
            if (busy[i] && station_out[i].valid_operands) begin
                consume     = '0;
                consume[i]  = 1'b1;
                issue.valid = 1'b1;
                issue.op    = station_out[i].op;
                issue.tag   = station_out[i].dest_tag;
                issue.a     = station_out[i].v_j;
                issue.b     = station_out[i].v_k;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/rs_bank.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank of RS_COUNT stations sharing one CDB
// a consumed station frees at the issue edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_bank
    import rs_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic [`RS_COUNT-1:0]  write_en,
    input  rs_entry_t             entry,
    input  cdb_packet_t           cdb,
    input  logic [`RS_COUNT-1:0]  consume,
    output logic [`RS_COUNT-1:0]  busy,
    output rs_out_t               station_out [`RS_COUNT]
);

    logic [`RS_COUNT-1:0] clear;

    // flush and reset hit every station, consume only its own
    assign clear = {`RS_COUNT{reset | flush}} | consume;

    for (genvar i = 0; i < `RS_COUNT; i++) begin : g_station
        rs_station u_station (
            .clk      (clk),
            .clear    (clear[i]),
            .write_en (write_en[i]),
            .entry    (entry),
            .cdb      (cdb),
            .busy     (busy[i]),
            .out      (station_out[i])
        );
    end

endmodule

`default_nettype wire

//--- src/rs_station.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// single reservation station with CDB snooping
// valid_operands lags the tags by one cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_station
    import rs_pkg::*;
(
    input  logic        clk,
    input  logic        clear,
    input  logic        write_en,
    input  rs_entry_t   entry,
    input  cdb_packet_t cdb,
    output logic        busy,
    output rs_out_t     out
);

    rs_entry_t q;
    logic      operands_ready;
    logic      hit_j;
    logic      hit_k;
    logic      fwd_j;
    logic      fwd_k;

    // wake-up on the held entry
    assign hit_j = cdb.valid && (q.q_j != '0) && (cdb.tag == q.q_j);
    assign hit_k = cdb.valid && (q.q_k != '0) && (cdb.tag == q.q_k);

    // same-edge broadcast for an entry being written
    assign fwd_j = cdb.valid && (entry.q_j != '0) && (cdb.tag == entry.q_j);
    assign fwd_k = cdb.valid && (entry.q_k != '0) && (cdb.tag == entry.q_k);

    always_ff @(posedge clk) begin
        if (clear) begin
            q.busy <= 1'b0;
        end else if (write_en) begin
            q <= entry;
            if (fwd_j) begin
                q.q_j <= '0;
                q.v_j <= cdb.result;
            end
            if (fwd_k) begin
                q.q_k <= '0;
                q.v_k <= cdb.result;
            end
        end else begin
            if (hit_j) begin
                q.q_j <= '0;
                q.v_j <= cdb.result;
            end
            if (hit_k) begin
                q.q_k <= '0;
                q.v_k <= cdb.result;
            end
        end
    end

    // sampled from the entry as it stood before this edge
    always_ff @(posedge clk) begin
        if (clear) begin
            operands_ready <= 1'b0;
        end else begin
            operands_ready <= q.busy && (q.q_j == '0) && (q.q_k == '0);
        end
    end

    assign busy = q.busy;

    always_comb begin
        out = '{valid_operands: operands_ready, op: q.op, dest_tag: q.dest_tag,
                v_j: q.v_j, v_k: q.v_k};
    end

endmodule

`default_nettype wire

//--- src/rs_dispatch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Wishbone classic write slave, single target
// ack withheld while every station is busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

module rs_dispatch
    import rs_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [$bits(rs_dispatch_t)-1:0]   wb_dat_w,
    input  logic [`RS_COUNT-1:0]              busy,
    output logic                              wb_ack,
    output logic [`RS_COUNT-1:0]              write_en,
    output rs_entry_t                         entry
);

    rs_dispatch_t word;
    logic         request;

    assign word = rs_dispatch_t'(wb_dat_w);

    // the ack cycle still shows stb, so it must not count as a new request
    assign request = wb_cyc && wb_stb && wb_we && !wb_ack;

    always_comb begin
        entry = '{busy: 1'b1, op: word.op, dest_tag: word.dest_tag,
                  q_j: word.q_j, v_j: word.v_j, q_k: word.q_k, v_k: word.v_k};
    end

    // lowest free station wins
    always_comb begin
        write_en = '0;
        for (int i = `RS_COUNT - 1; i >= 0; i--) begin
            if (request && !busy[i]) begin
                write_en    = '0;
                write_en[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= |write_en;
        end
    end

endmodule

`default_nettype wire

//--- src/fu_issue_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one issued operation, select to ALU
// no ready, the ALU takes a new op every cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

interface fu_issue_if
    import rs_pkg::*;
();

    logic                valid;
    alu_op_t             op;
    logic [`TAG_W-1:0]   tag;
    logic [`DATA_W-1:0]  a;
    logic [`DATA_W-1:0]  b;

    // select side
    modport sel (output valid, op, tag, a, b);

    // execution side
    modport alu (input valid, op, tag, a, b);

endinterface

`default_nettype wire

//--- src/rs_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for dispatch, stations, select and ALU
// dispatch word layout must match the testbench packing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

`include "rs_macros.svh"

package rs_pkg;

    // shifts use b[4:0], slt is signed
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_t;

    // 76-bit Wishbone write data, most significant field first
    typedef struct packed {
        alu_op_t              op;
        logic [`TAG_W-1:0]    dest_tag;
        logic [`TAG_W-1:0]    q_j;
        logic [`DATA_W-1:0]   v_j;
        logic [`TAG_W-1:0]    q_k;
        logic [`DATA_W-1:0]   v_k;
    } rs_dispatch_t;

    // stored station entry, the dispatch word with busy on top
    typedef struct packed {
        logic                 busy;
        alu_op_t              op;
        logic [`TAG_W-1:0]    dest_tag;
        logic [`TAG_W-1:0]    q_j;
        logic [`DATA_W-1:0]   v_j;
        logic [`TAG_W-1:0]    q_k;
        logic [`DATA_W-1:0]   v_k;
    } rs_entry_t;

    // station view seen by select
    typedef struct packed {
        logic                 valid_operands;
        alu_op_t              op;
        logic [`TAG_W-1:0]    dest_tag;
        logic [`DATA_W-1:0]   v_j;
        logic [`DATA_W-1:0]   v_k;
    } rs_out_t;

    typedef struct packed {
        logic                 valid;
        logic [`TAG_W-1:0]    tag;
        logic [`DATA_W-1:0]   result;
    } cdb_packet_t;

endpackage

`default_nettype wire

//--- src/rs_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizing for the reservation-station block
// tag 0 is reserved and means operand present
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef RS_MACROS_SVH
`define RS_MACROS_SVH

// stations in the bank, one-hot vectors are this wide
`define RS_COUNT 4

// ROB tag width, the testbench hands out tags 1..7
`define TAG_W 3

// operand and result width
`define DATA_W 32

`endif
